// ==== Bender.yml ====
package:
  name: riscCore

sources:
  - files:
      - source/corePkg.sv
      - source/controlUnit.sv
      - source/aluCore.sv
      - source/regFile.sv
      - source/dataPath.sv
      - source/riscCore.sv
  - target: test
    files:
      - test/coreChecker.sv
      - test/riscCoreTb.sv

// ==== riscCore.f ====
source/corePkg.sv
source/controlUnit.sv
source/aluCore.sv
source/regFile.sv
source/dataPath.sv
source/riscCore.sv
test/coreChecker.sv
test/riscCoreTb.sv

// ==== source/aluCore.sv ====
module aluCore import corePkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluOp_t          aluOp,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic lessThan;

    // Signed compare for SLT
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lessThan};
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // Used for BEQ/BNE after a subtract
    assign zero = (result == '0);

endmodule

// ==== source/controlUnit.sv ====
module controlUnit import corePkg::*; (
    input  instrWord_t instr,
    output ctrlSig_t   ctrl,
    output logic       illegalInstr
);

    always_comb begin
        // Defaults describe a no-op
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.immSel    = IMM_I;
        ctrl.resultSel = RES_ALU;
        ctrl.branch    = 1'b0;
        ctrl.branchNe  = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.aluOp     = ALU_ADD;
        illegalInstr   = 1'b0;

        case (instr.rFmt.opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (instr.rFmt.funct7)
                    F7_BASE: begin
                        case (instr.rFmt.funct3)
                            F3_ADD:  ctrl.aluOp = ALU_ADD;
                            F3_SLT:  ctrl.aluOp = ALU_SLT;
                            F3_XOR:  ctrl.aluOp = ALU_XOR;
                            F3_OR:   ctrl.aluOp = ALU_OR;
                            F3_AND:  ctrl.aluOp = ALU_AND;
                            default: illegalInstr = 1'b1;
                        endcase
                    end
                    F7_SUB: begin
                        if (instr.rFmt.funct3 == F3_ADD) ctrl.aluOp = ALU_SUB;
                        else illegalInstr = 1'b1;
                    end
                    default: illegalInstr = 1'b1;
                endcase
            end
            OP_ITYPE: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                // No SLTI in this core
                case (instr.iFmt.funct3)
                    F3_ADD:  ctrl.aluOp = ALU_ADD;
                    F3_XOR:  ctrl.aluOp = ALU_XOR;
                    F3_OR:   ctrl.aluOp = ALU_OR;
                    F3_AND:  ctrl.aluOp = ALU_AND;
                    default: illegalInstr = 1'b1;
                endcase
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSel = RES_MEM;
                if (instr.iFmt.funct3 != F3_WORD) illegalInstr = 1'b1;
            end
            OP_STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = IMM_S;
                if (instr.sFmt.funct3 != F3_WORD) illegalInstr = 1'b1;
            end
            OP_BRANCH: begin
                // Subtract so that zero means equal
                ctrl.branch   = 1'b1;
                ctrl.immSel   = IMM_B;
                ctrl.aluOp    = ALU_SUB;
                ctrl.branchNe = (instr.bFmt.funct3 == F3_BNE);
                if (instr.bFmt.funct3 != F3_BEQ && instr.bFmt.funct3 != F3_BNE) begin
                    illegalInstr = 1'b1;
                end
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.immSel    = IMM_J;
                ctrl.resultSel = RES_PC4;
            end
            default: illegalInstr = 1'b1;
        endcase

        // Illegal encodings fall through as a plain pc+4
        if (illegalInstr) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
            ctrl.jump     = 1'b0;
        end
    end

endmodule

// ==== source/corePkg.sv ====
package corePkg;

    // Data and address width
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Funct3 codes for ALU, branch and memory instructions
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    // Funct7 for plain R-type ops and for SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_t;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J
    } immSel_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } resultSel_t;

    // One instruction word seen through its encoding formats
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } rFmt;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } iFmt;
        struct packed {
            logic [6:0]            immHi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            immLo;
            logic [6:0]            opcode;
        } sFmt;
        // B layout; JAL's immediate is also pulled from these raw bits
        struct packed {
            logic [6:0]            immHi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            immLo;
            logic [6:0]            opcode;
        } bFmt;
    } instrWord_t;

    // Decoded controls for the datapath
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       aluSrcImm;
        immSel_t    immSel;
        resultSel_t resultSel;
        logic       branch;
        logic       branchNe;
        logic       jump;
        aluOp_t     aluOp;
    } ctrlSig_t;

endpackage

// ==== source/dataPath.sv ====
module dataPath import corePkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  instrWord_t      instr,
    input  ctrlSig_t        ctrl,
    input  logic [XLEN-1:0] readData,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] dataAddr,
    output logic [XLEN-1:0] writeData
);

    logic [XLEN-1:0] immExt;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic            zero;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] pcNext;
    logic            taken;

    // Immediate extraction per format
    always_comb begin
        case (ctrl.immSel)
            IMM_I: begin
                immExt = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
            end
            IMM_S: begin
                immExt = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            end
            IMM_B: begin
                immExt = {{20{instr.bFmt.immHi[6]}}, instr.bFmt.immLo[0],
                          instr.bFmt.immHi[5:0], instr.bFmt.immLo[4:1], 1'b0};
            end
            default: begin
                // JAL bits rebuilt from the B view fields
                immExt = {{12{instr.bFmt.immHi[6]}}, instr.bFmt.rs1, instr.bFmt.funct3,
                          instr.bFmt.rs2[0], instr.bFmt.immHi[5:0],
                          instr.bFmt.rs2[4:1], 1'b0};
            end
        endcase
    end

    regFile regFile0 (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (instr.rFmt.rs1),
        .rs2Addr (instr.rFmt.rs2),
        .rdAddr  (instr.rFmt.rd),
        .rdData  (result),
        .rdWrite (ctrl.regWrite),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign srcB = ctrl.aluSrcImm ? immExt : rs2Data;

    aluCore alu0 (
        .a      (rs1Data),
        .b      (srcB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    // Memory port
    assign dataAddr  = aluResult;
    assign writeData = rs2Data;

    // Next pc
    assign pcPlus4  = pc + XLEN'(4);
    assign pcTarget = pc + immExt;
    assign taken    = ctrl.jump || (ctrl.branch && (zero != ctrl.branchNe));
    assign pcNext   = taken ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Write-back source
    always_comb begin
        case (ctrl.resultSel)
            RES_MEM: result = readData;
            RES_PC4: result = pcPlus4;
            default: result = aluResult;
        endcase
    end

    // Targets are word aligned, so pc never drifts off alignment
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

// ==== source/regFile.sv ====
module regFile import corePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [REG_ADDR_W-1:0] rs1Addr,
    input  logic [REG_ADDR_W-1:0] rs2Addr,
    input  logic [REG_ADDR_W-1:0] rdAddr,
    input  logic [XLEN-1:0]       rdData,
    input  logic                  rdWrite,
    output logic [XLEN-1:0]       rs1Data,
    output logic [XLEN-1:0]       rs2Data
);

    // Storage for x1 to x31 only
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrite && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== source/riscCore.sv ====
module riscCore import corePkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] readData,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] dataAddr,
    output logic [XLEN-1:0] writeData,
    output logic            memWrite,
    output logic            illegalInstr
);

    instrWord_t instrWord;
    ctrlSig_t   ctrl;

    assign instrWord = instr;

    // Decoder
    controlUnit ctrl0 (
        .instr        (instrWord),
        .ctrl         (ctrl),
        .illegalInstr (illegalInstr)
    );

    // Register file, ALU and pc
    dataPath dp0 (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instrWord),
        .ctrl      (ctrl),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData)
    );

    // No store strobe while the core is held in reset
    assign memWrite = rstN && ctrl.memWrite;

endmodule

// ==== test/coreChecker.sv ====
module coreChecker import corePkg::*; (
    input logic            clk,
    input logic            rstN,
    input logic [XLEN-1:0] pc,
    input logic [XLEN-1:0] instr,
    input logic [XLEN-1:0] dataAddr,
    input logic [XLEN-1:0] writeData,
    input logic            memWrite,
    input logic            illegalInstr
);

    logic [XLEN-1:0] modelRegs [0:31];
    logic [XLEN-1:0] modelMem [0:255];
    logic [XLEN-1:0] modelPc;
    logic            expStore;
    logic            expIllegal;
    logic [XLEN-1:0] expAddr;
    logic [XLEN-1:0] expData;
    int checks = 0;
    int errors = 0;
    int totalChecks = 0;
    int totalErrors = 0;
    int testCount = 0;

    // ISA reference for one instruction on the model state
    function automatic void execute(input logic [31:0] w);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] next;
        logic        legal;
        logic        wr;
        rd = w[11:7];
        rs1 = w[19:15];
        rs2 = w[24:20];
        f3 = w[14:12];
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        next = modelPc + 32'd4;
        legal = 1'b1;
        wr = 1'b0;
        res = '0;
        expStore = 1'b0;
        expAddr = '0;
        expData = '0;
        case (w[6:0])
            OP_RTYPE, OP_ITYPE: begin
                wr = 1'b1;
                if (w[6:0] == OP_ITYPE) b = immI;
                if (w[6:0] == OP_RTYPE && w[31:25] == 7'h20 && f3 == F3_ADD) res = a - b;
                else if (w[6:0] == OP_RTYPE && w[31:25] != 7'h00) legal = 1'b0;
                else begin
                    case (f3)
                        F3_ADD: res = a + b;
                        F3_XOR: res = a ^ b;
                        F3_OR:  res = a | b;
                        F3_AND: res = a & b;
                        F3_SLT: begin
                            // SLTI is outside the supported set
                            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            legal = (w[6:0] == OP_RTYPE);
                        end
                        default: legal = 1'b0;
                    endcase
                end
            end
            OP_LOAD: begin
                wr = 1'b1;
                legal = (f3 == F3_WORD);
                addr = a + immI;
                res = modelMem[addr[9:2]];
            end
            OP_STORE: begin
                legal = (f3 == F3_WORD);
                addr = a + immS;
                if (legal) begin
                    expStore = 1'b1;
                    expAddr = addr;
                    expData = b;
                    modelMem[addr[9:2]] = b;
                end
            end
            OP_BRANCH: begin
                legal = (f3 == F3_BEQ) || (f3 == F3_BNE);
                if (legal && ((a == b) != f3[0])) next = modelPc + immB;
            end
            OP_JAL: begin
                wr = 1'b1;
                res = modelPc + 32'd4;
                next = modelPc + immJ;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) next = modelPc + 32'd4;
        if (legal && wr && rd != 5'd0) modelRegs[rd] = res;
        expIllegal = !legal;
        modelPc = next;
    endfunction

    task automatic checkValue(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("Test %0d %s: %0d checks, %0d errors", testCount, name, checks, errors);
        totalChecks += checks;
        totalErrors += errors;
        checks = 0;
        errors = 0;
    endtask

    // Lockstep compare, then step the model past the committed instruction
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                modelRegs[i] = '0;
            end
            modelPc = '0;
        end else begin
            checkValue("pc", modelPc, pc);
            execute(instr);
            checkValue("memWrite", XLEN'(expStore), XLEN'(memWrite));
            checkValue("illegalInstr", XLEN'(expIllegal), XLEN'(illegalInstr));
            if (expStore) begin
                checkValue("dataAddr", expAddr, dataAddr);
                checkValue("writeData", expData, writeData);
            end
        end
    end

endmodule

// ==== test/riscCoreTb.sv ====
module riscCoreTb import corePkg::*; ();

    logic            clk;
    logic            rstN;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] readData;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] dataAddr;
    logic [XLEN-1:0] writeData;
    logic            memWrite;
    logic            illegalInstr;
    logic [31:0]     instrMem [0:255];
    logic [31:0]     dataMem [0:255];
    logic [31:0]     prog [$];
    logic [15:0]     lfsrState;
    int              timeouts;

    localparam int RUN_LIMIT = 2000;

    riscCore dut0 (.clk(clk), .rstN(rstN), .instr(instr), .readData(readData), .pc(pc),
                   .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite),
                   .illegalInstr(illegalInstr));

    coreChecker chk0 (.clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .dataAddr(dataAddr),
                      .writeData(writeData), .memWrite(memWrite),
                      .illegalInstr(illegalInstr));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Combinational reads and stores on the rising edge
    assign instr = instrMem[pc[9:2]];
    assign readData = dataMem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (memWrite) dataMem[dataAddr[9:2]] <= writeData;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] pickReg(input int lo, input int count);
        return 5'(lo + int'(randBits(5)) % count);
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs1, rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] randomR(input logic [4:0] rd);
        logic [2:0] sel;
        logic [2:0] f3s [0:4];
        f3s = '{F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND};
        sel = 3'(randBits(3));
        if (sel > 3'd4) return encR(F7_SUB, F3_ADD, rd, pickReg(0, 16), pickReg(0, 16));
        return encR(F7_BASE, f3s[sel], rd, pickReg(0, 16), pickReg(0, 16));
    endfunction

    function automatic logic [31:0] illegalWord();
        logic [31:0] w;
        logic [2:0]  sel;
        logic [6:0]  ops [0:3];
        ops = '{7'b0110111, 7'b0010111, 7'b1100111, 7'b1110011};
        w = randBits(32);
        sel = 3'(randBits(3));
        case (sel)
            3'd4: w = {7'h01, w[24:7], OP_RTYPE};
            3'd5: w = {w[31:15], F3_SLT, w[11:7], OP_ITYPE};
            3'd6: w = {w[31:15], 3'b000, w[11:7], OP_STORE};
            3'd7: w = {w[31:15], 3'b010, w[11:7], OP_BRANCH};
            default: w[6:0] = ops[sel[1:0]];
        endcase
        return w;
    endfunction

    task automatic seedRegs(input int count);
        for (int r = 1; r <= count; r++) begin
            prog.push_back(encI(OP_ITYPE, F3_ADD, 5'(r), 5'd0, 12'(randBits(12))));
        end
    endtask

    task automatic loadMemories();
        for (int i = 0; i < 256; i++) begin
            // Unused slots hold ADDI x0, x0, index
            instrMem[i] = (i < prog.size()) ? prog[i]
                                            : encI(OP_ITYPE, F3_ADD, 5'd0, 5'd0, 12'(i));
            dataMem[i] = {8'(i) ^ 8'h5A, ~8'(i), 8'(i), 8'(i) ^ 8'hC3};
            chk0.modelMem[i] = {8'(i) ^ 8'h5A, ~8'(i), 8'(i), 8'(i) ^ 8'hC3};
        end
    endtask

    // Dumps every register, then spins on a JAL to itself
    task automatic runProgram(input string name);
        logic [31:0] endPc;
        logic        reached;
        for (int r = 0; r < 3; r++) begin
            prog.push_back(encI(OP_ITYPE, F3_ADD, 5'd0, 5'd0, 12'd0));
        end
        for (int r = 0; r < 32; r++) begin
            prog.push_back(encS(5'd0, 5'(r), 12'(512 + 4 * r)));
        end
        endPc = prog.size() * 4;
        prog.push_back(encJ(5'd0, 21'd0));
        @(negedge clk);
        rstN = 1'b0;
        loadMemories();
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        reached = 1'b0;
        for (int cyc = 0; cyc < RUN_LIMIT && !reached; cyc++) begin
            @(negedge clk);
            reached = (pc == endPc);
        end
        if (!reached) begin
            timeouts++;
            $display("Timeout: %s never reached its final instruction", name);
        end
        chk0.reportTest(name);
        prog.delete();
    endtask

    initial begin
        rstN = 1'b0;
        lfsrState = 16'd79;
        timeouts = 0;
        loadMemories();

        seedRegs(15);
        repeat (40) prog.push_back(randomR(pickReg(1, 15)));
        runProgram("register ALU");

        seedRegs(8);
        repeat (40) begin
            prog.push_back(encI(OP_ITYPE, randBits(1) ? F3_ADD : (randBits(1) ? F3_XOR
                : (randBits(1) ? F3_OR : F3_AND)), pickReg(1, 15), pickReg(0, 16),
                12'(randBits(12))));
        end
        runProgram("immediate");

        // x10 is the load and store base and is never overwritten
        seedRegs(9);
        prog.push_back(encI(OP_ITYPE, F3_ADD, 5'd10, 5'd0, 12'd256));
        repeat (30) begin
            case (randBits(2))
                2'd0: prog.push_back(encI(OP_LOAD, F3_WORD, pickReg(1, 9), 5'd10,
                                          12'(4 * randBits(5))));
                2'd1: prog.push_back(encS(5'd10, pickReg(0, 10), 12'(4 * randBits(5))));
                default: prog.push_back(randomR(pickReg(1, 9)));
            endcase
        end
        runProgram("load store");

        seedRegs(4);
        repeat (30) begin
            case (randBits(2))
                2'd0: prog.push_back(encB(F3_BEQ, pickReg(1, 4), pickReg(1, 4),
                                          13'(4 * (1 + randBits(2) % 3))));
                2'd1: prog.push_back(encB(F3_BNE, pickReg(1, 4), pickReg(1, 4),
                                          13'(4 * (1 + randBits(2) % 3))));
                2'd2: prog.push_back(encJ(pickReg(5, 5), 21'(4 * (1 + randBits(2) % 3))));
                default: prog.push_back(encI(OP_ITYPE, F3_ADD, pickReg(1, 4), 5'd0,
                                             12'(randBits(2))));
            endcase
        end
        runProgram("control flow");

        seedRegs(9);
        repeat (24) begin
            case (randBits(2))
                2'd0: prog.push_back(encI(OP_ITYPE, F3_ADD, 5'd0, pickReg(1, 9),
                                          12'(randBits(12))));
                2'd1: prog.push_back(randomR(5'd0));
                2'd2: prog.push_back(encI(OP_LOAD, F3_WORD, 5'd0, 5'd0, 12'(4 * randBits(6))));
                default: prog.push_back(encJ(5'd0, 21'd4));
            endcase
        end
        prog.push_back(encR(F7_BASE, F3_OR, 5'd11, 5'd0, 5'd0));
        runProgram("x0 writes");

        seedRegs(9);
        repeat (24) begin
            if (randBits(1)) prog.push_back(illegalWord());
            else prog.push_back(encI(OP_ITYPE, F3_ADD, pickReg(1, 9), pickReg(0, 10),
                                     12'(randBits(12))));
        end
        runProgram("illegal encodings");

        $display("Tests %0d, checks %0d, errors %0d, timeouts %0d",
                 chk0.testCount, chk0.totalChecks, chk0.totalErrors, timeouts);
        if (chk0.totalErrors == 0 && timeouts == 0 && chk0.totalChecks > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
